// File: src/matrix_calc_pkg.sv
/* shared sizes, types and encodings of the matrix calculator core
   matrices are stored compact row-major, so cell index = row * n + col */
package matrix_calc_pkg;

	// ==================================================
	// sizes
	// ==================================================
	localparam int MAX_DIM  = 5;                  // rows or cols, 1..5
	localparam int CELLS    = MAX_DIM * MAX_DIM;  // cells per slot
	localparam int ELEM_W   = 8;                  // one element byte
	localparam int ELEM_MAX = 9;                  // largest element and scalar
	localparam int DIM_W    = 3;
	localparam int IDX_W    = 5;                  // 0..24 cell index
	localparam int RES_W    = 16;                 // 5 * 9 * 9 = 405 fits

	// error hold, TICK_CYCLES * HOLD_TICKS = 48 cycles
	localparam int TICK_CYCLES = 16;
	localparam int HOLD_TICKS  = 3;

	// ==================================================
	// types
	// ==================================================
	typedef logic [DIM_W-1:0]  dim_t;
	typedef logic [IDX_W-1:0]  idx_t;
	typedef logic [ELEM_W-1:0] elem_t;
	typedef logic [RES_W-1:0]  res_t;
	typedef elem_t [CELLS-1:0] mat_t;   // whole slot, cell 0 in the low byte

	// command[2:0], codes 4..7 are illegal
	typedef enum logic [2:0] {
		OP_TRANSPOSE = 3'd0,
		OP_SCALAR    = 3'd1,
		OP_ADD       = 3'd2,
		OP_MULTIPLY  = 3'd3
	} op_e;

	typedef enum logic [2:0] {
		IDLE,
		CHECK,
		COMPUTE,
		SEND,
		ERROR
	} calc_state_e;

	typedef enum logic [1:0] {
		GET_M,
		GET_N,
		GET_ELEM
	} load_state_e;

endpackage

// File: src/matrix_loader.sv
/* a bad byte drops the matrix in progress and the next byte is taken as a new m
   no timeout on a partial matrix, a stalled stream waits forever */
`timescale 1ns/100ps

module matrix_loader (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   rx_valid,
	input  logic [7:0]             rx_data,
	output logic                   wr_en,
	output logic                   wr_slot,
	output matrix_calc_pkg::dim_t  wr_m,
	output matrix_calc_pkg::dim_t  wr_n,
	output matrix_calc_pkg::mat_t  wr_data,
	output logic                   load_error
);

	matrix_calc_pkg::load_state_e state;
	matrix_calc_pkg::dim_t        m_q;
	matrix_calc_pkg::dim_t        n_q;
	matrix_calc_pkg::idx_t        cnt;       // element being collected
	matrix_calc_pkg::idx_t        last_idx;
	matrix_calc_pkg::mat_t        elem_buf;
	logic                         slot;      // 0 = A, 1 = B
	logic                         dim_ok;
	logic                         elem_ok;

	assign dim_ok   = (rx_data != 8'd0) && (rx_data <= 8'(matrix_calc_pkg::MAX_DIM));
	assign elem_ok  = rx_data <= 8'(matrix_calc_pkg::ELEM_MAX);
	assign last_idx = matrix_calc_pkg::idx_t'(m_q) * matrix_calc_pkg::idx_t'(n_q) - 1'b1;

	assign wr_slot = slot;
	assign wr_m    = m_q;
	assign wr_n    = n_q;
	assign wr_data = elem_buf;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= matrix_calc_pkg::GET_M;
			m_q        <= '0;
			n_q        <= '0;
			cnt        <= '0;
			slot       <= 1'b0;
			wr_en      <= 1'b0;
			load_error <= 1'b0;
		end else begin
			wr_en      <= 1'b0;
			load_error <= 1'b0;
			if (wr_en)
				slot <= ~slot;  // alternate after each accepted matrix
			if (rx_valid) begin
				unique case (state)
					matrix_calc_pkg::GET_M: begin
						m_q <= matrix_calc_pkg::dim_t'(rx_data);
						if (dim_ok)
							state <= matrix_calc_pkg::GET_N;
						else
							load_error <= 1'b1;
					end
					matrix_calc_pkg::GET_N: begin
						n_q <= matrix_calc_pkg::dim_t'(rx_data);
						cnt <= '0;
						load_error <= !dim_ok;
						state <= dim_ok ? matrix_calc_pkg::GET_ELEM : matrix_calc_pkg::GET_M;
					end
					default: begin  // GET_ELEM
						if (!elem_ok) begin
							load_error <= 1'b1;
							state <= matrix_calc_pkg::GET_M;
						end else if (cnt == last_idx) begin
							wr_en <= 1'b1;  // store takes it on the next edge
							state <= matrix_calc_pkg::GET_M;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
				endcase
			end
		end
	end

	// element payload
	always_ff @(posedge clk) begin
		if (rx_valid && elem_ok && state == matrix_calc_pkg::GET_ELEM)
			elem_buf[cnt] <= rx_data;
	end

	wr_dims_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> (wr_m != '0) && (wr_n != '0));

endmodule

// File: src/matrix_store.sv
/* slot 0 is operand A, slot 1 is operand B
   cells beyond m * n hold stale data from older loads */
`timescale 1ns/100ps

module matrix_store (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  wr_en,
	input  logic                  wr_slot,
	input  matrix_calc_pkg::dim_t wr_m,
	input  matrix_calc_pkg::dim_t wr_n,
	input  matrix_calc_pkg::mat_t wr_data,
	output matrix_calc_pkg::dim_t a_m,
	output matrix_calc_pkg::dim_t a_n,
	output matrix_calc_pkg::mat_t a_data,
	output logic                  a_valid,
	output matrix_calc_pkg::dim_t b_m,
	output matrix_calc_pkg::dim_t b_n,
	output matrix_calc_pkg::mat_t b_data,
	output logic                  b_valid
);

	matrix_calc_pkg::dim_t m_r    [2];
	matrix_calc_pkg::dim_t n_r    [2];
	matrix_calc_pkg::mat_t data_r [2];
	logic [1:0]            valid_r;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			valid_r <= '0;  // both slots empty
		else if (wr_en)
			valid_r[wr_slot] <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			m_r[wr_slot]    <= wr_m;
			n_r[wr_slot]    <= wr_n;
			data_r[wr_slot] <= wr_data;
		end
	end

	// both slots always visible to the ALU
	assign a_m     = m_r[0];
	assign a_n     = n_r[0];
	assign a_data  = data_r[0];
	assign a_valid = valid_r[0];
	assign b_m     = m_r[1];
	assign b_n     = n_r[1];
	assign b_data  = data_r[1];
	assign b_valid = valid_r[1];

	wr_dims_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> (wr_m <= matrix_calc_pkg::MAX_DIM) && (wr_n <= matrix_calc_pkg::MAX_DIM));

endmodule

// File: src/matrix_alu.sv
/* operands are read live from the store, so no load may land while a run is going
   multiply costs one cycle per inner term, the other ops one cycle per element */
`timescale 1ns/100ps

module matrix_alu (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   alu_start,
	input  matrix_calc_pkg::op_e   op,
	input  matrix_calc_pkg::elem_t scalar,
	input  matrix_calc_pkg::dim_t  a_m,
	input  matrix_calc_pkg::dim_t  a_n,
	input  matrix_calc_pkg::mat_t  a_data,
	input  logic                   a_valid,
	input  matrix_calc_pkg::dim_t  b_m,
	input  matrix_calc_pkg::dim_t  b_n,
	input  matrix_calc_pkg::mat_t  b_data,
	input  logic                   b_valid,
	input  matrix_calc_pkg::idx_t  rd_idx,
	output logic                   alu_done,
	output logic                   alu_ok,
	output matrix_calc_pkg::dim_t  res_m,
	output matrix_calc_pkg::dim_t  res_n,
	output matrix_calc_pkg::res_t  rd_elem
);

	matrix_calc_pkg::res_t res_buf [matrix_calc_pkg::CELLS];
	matrix_calc_pkg::dim_t r, c, k;     // result row, result col, inner term
	matrix_calc_pkg::dim_t rm, rn;      // result dims, latched at start
	matrix_calc_pkg::res_t acc, val;
	matrix_calc_pkg::idx_t a_rc, a_cr, a_rk, b_kc, out_idx;
	logic running;
	logic fit;
	logic k_last;
	logic last_cell;

	// ==================================================
	// index math, row-major on each operand's own n
	// ==================================================
	assign a_rc    = matrix_calc_pkg::idx_t'(r) * matrix_calc_pkg::idx_t'(a_n) + matrix_calc_pkg::idx_t'(c);
	assign a_cr    = matrix_calc_pkg::idx_t'(c) * matrix_calc_pkg::idx_t'(a_n) + matrix_calc_pkg::idx_t'(r);
	assign a_rk    = matrix_calc_pkg::idx_t'(r) * matrix_calc_pkg::idx_t'(a_n) + matrix_calc_pkg::idx_t'(k);
	assign b_kc    = matrix_calc_pkg::idx_t'(k) * matrix_calc_pkg::idx_t'(b_n) + matrix_calc_pkg::idx_t'(c);
	assign out_idx = matrix_calc_pkg::idx_t'(r) * matrix_calc_pkg::idx_t'(rn) + matrix_calc_pkg::idx_t'(c);

	assign k_last    = (op != matrix_calc_pkg::OP_MULTIPLY) || (k == a_n - 1'b1);
	assign last_cell = (r == rm - 1'b1) && (c == rn - 1'b1);

	// operand validity and shape fit, the only dimension check in the core
	always_comb begin
		unique case (op)
			matrix_calc_pkg::OP_TRANSPOSE,
			matrix_calc_pkg::OP_SCALAR:   fit = a_valid;
			matrix_calc_pkg::OP_ADD:      fit = a_valid && b_valid && a_m == b_m && a_n == b_n;
			matrix_calc_pkg::OP_MULTIPLY: fit = a_valid && b_valid && a_n == b_m;
			default:                      fit = 1'b0;
		endcase
	end

	// value of the current step
	always_comb begin
		unique case (op)
			matrix_calc_pkg::OP_TRANSPOSE: val = matrix_calc_pkg::res_t'(a_data[a_cr]);
			matrix_calc_pkg::OP_SCALAR:    val = matrix_calc_pkg::res_t'(a_data[a_rc]) * matrix_calc_pkg::res_t'(scalar);
			matrix_calc_pkg::OP_ADD:       val = matrix_calc_pkg::res_t'(a_data[a_rc]) + matrix_calc_pkg::res_t'(b_data[a_rc]);
			matrix_calc_pkg::OP_MULTIPLY:  val = acc + matrix_calc_pkg::res_t'(a_data[a_rk]) * matrix_calc_pkg::res_t'(b_data[b_kc]);
			default:                       val = '0;
		endcase
	end

	// ==================================================
	// sequencing
	// ==================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			running <= 1'b0;
			alu_done <= 1'b0;
			alu_ok <= 1'b0;
			{r, c, k} <= '0;
			{rm, rn} <= '0;
			acc <= '0;
		end else begin
			alu_done <= 1'b0;
			if (alu_start) begin
				{r, c, k} <= '0;
				acc <= '0;
				running <= fit;
				alu_done <= !fit;  // refused at once
				alu_ok <= 1'b0;
				rm <= (op == matrix_calc_pkg::OP_TRANSPOSE) ? a_n : a_m;
				rn <= (op == matrix_calc_pkg::OP_TRANSPOSE) ? a_m :
					(op == matrix_calc_pkg::OP_MULTIPLY) ? b_n : a_n;
			end else if (running) begin
				if (!k_last) begin
					acc <= val;  // partial inner product
					k <= k + 1'b1;
				end else begin
					acc <= '0;
					k <= '0;
					if (last_cell) begin
						running <= 1'b0;
						alu_done <= 1'b1;
						alu_ok <= 1'b1;
					end else if (c == rn - 1'b1) begin
						c <= '0;
						r <= r + 1'b1;
					end else begin
						c <= c + 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (running && k_last)
			res_buf[out_idx] <= val;
	end

	assign res_m   = rm;
	assign res_n   = rn;
	assign rd_elem = res_buf[rd_idx];  // combinational read for the sender

	no_restart: assert property (@(posedge clk) disable iff (!rst_n)
		alu_start |-> !running);

endmodule

// File: src/result_sender.sv
/* byte order is m, n, then each element high byte first
   at most one byte every second cycle, held while tx_busy is high */
`timescale 1ns/100ps

module result_sender (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  send_start,
	input  logic                  tx_busy,
	input  matrix_calc_pkg::dim_t res_m,
	input  matrix_calc_pkg::dim_t res_n,
	input  matrix_calc_pkg::res_t rd_elem,
	output matrix_calc_pkg::idx_t rd_idx,
	output logic                  tx_start,
	output logic [7:0]            tx_data,
	output logic                  send_done
);

	logic                              active;
	logic                              gap;        // idle cycle after a byte
	logic [matrix_calc_pkg::IDX_W:0]   byte_idx;   // 0 m, 1 n, then hi/lo pairs
	logic [matrix_calc_pkg::IDX_W:0]   elem_byte;
	logic [matrix_calc_pkg::IDX_W:0]   last_byte;

	assign last_byte = {matrix_calc_pkg::idx_t'(res_m) * matrix_calc_pkg::idx_t'(res_n), 1'b1};
	assign elem_byte = byte_idx - 2'd2;
	assign rd_idx    = elem_byte[matrix_calc_pkg::IDX_W:1];  // two bytes per element

	assign tx_start = active && !gap && !tx_busy;

	always_comb begin
		if (byte_idx == '0)
			tx_data = 8'(res_m);
		else if (byte_idx == 1)
			tx_data = 8'(res_n);
		else if (!byte_idx[0])
			tx_data = rd_elem[matrix_calc_pkg::RES_W-1 -: 8];
		else
			tx_data = rd_elem[7:0];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			gap <= 1'b0;
			byte_idx <= '0;
			send_done <= 1'b0;
		end else begin
			send_done <= 1'b0;
			gap <= tx_start;
			if (send_start) begin
				active <= 1'b1;
				byte_idx <= '0;
			end else if (tx_start) begin
				if (byte_idx == last_byte) begin
					active <= 1'b0;
					send_done <= 1'b1;
				end else begin
					byte_idx <= byte_idx + 1'b1;
				end
			end
		end
	end

	tx_handshake: assert property (@(posedge clk) disable iff (!rst_n)
		tx_start |-> !tx_busy ##1 !tx_start);

endmodule

// File: src/countdown_timer.sv
/* fixed hold of TICK_CYCLES * HOLD_TICKS cycles, a new start restarts it */
`timescale 1ns/100ps

module countdown_timer (
	input  logic clk,
	input  logic rst_n,
	input  logic timer_start,
	output logic active,
	output logic expired
);

	logic [$clog2(matrix_calc_pkg::TICK_CYCLES)-1:0] presc;
	logic [$clog2(matrix_calc_pkg::HOLD_TICKS)-1:0]  ticks;  // ticks left after this one

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			expired <= 1'b0;
			presc <= '0;
			ticks <= '0;
		end else begin
			expired <= 1'b0;
			if (timer_start) begin
				active <= 1'b1;
				presc <= '0;
				ticks <= ($clog2(matrix_calc_pkg::HOLD_TICKS))'(matrix_calc_pkg::HOLD_TICKS - 1);
			end else if (active) begin
				if (presc == ($clog2(matrix_calc_pkg::TICK_CYCLES))'(matrix_calc_pkg::TICK_CYCLES - 1)) begin
					presc <= '0;
					if (ticks == '0) begin
						active <= 1'b0;
						expired <= 1'b1;  // one cycle
					end else begin
						ticks <= ticks - 1'b1;
					end
				end else begin
					presc <= presc + 1'b1;
				end
			end
		end
	end

endmodule

// File: src/calc_fsm.sv
/* opcode and scalar are sampled on the confirm cycle only
   a load error seen while busy is kept and taken once the core is idle */
`timescale 1ns/100ps

module calc_fsm (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   confirm,
	input  logic [7:0]             command,
	input  logic [7:0]             scalar_in,
	input  logic                   load_error,
	input  logic                   alu_done,
	input  logic                   alu_ok,
	input  logic                   send_done,
	input  logic                   timer_active,
	input  logic                   timer_expired,
	output logic                   alu_start,
	output matrix_calc_pkg::op_e   op,
	output matrix_calc_pkg::elem_t scalar,
	output logic                   send_start,
	output logic                   timer_start,
	output logic                   busy,
	output logic                   error
);

	matrix_calc_pkg::calc_state_e state, next_state;
	logic [2:0]                   op_q;       // raw, may be illegal
	matrix_calc_pkg::elem_t       scalar_q;
	logic                         load_err_q;
	logic                         bad_cmd;

	assign bad_cmd = (op_q > 3'(matrix_calc_pkg::OP_MULTIPLY)) ||
		(op_q == matrix_calc_pkg::OP_SCALAR && scalar_q > 8'(matrix_calc_pkg::ELEM_MAX));

	// ==================================================
	// next state
	// ==================================================
	always_comb begin
		next_state = state;
		unique case (state)
			matrix_calc_pkg::IDLE: begin
				if (load_error || load_err_q)
					next_state = matrix_calc_pkg::ERROR;
				else if (confirm && !timer_active)
					next_state = matrix_calc_pkg::CHECK;
			end
			matrix_calc_pkg::CHECK:
				next_state = bad_cmd ? matrix_calc_pkg::ERROR : matrix_calc_pkg::COMPUTE;
			matrix_calc_pkg::COMPUTE: begin
				if (alu_done)
					next_state = alu_ok ? matrix_calc_pkg::SEND : matrix_calc_pkg::ERROR;
			end
			matrix_calc_pkg::SEND: begin
				if (send_done)
					next_state = matrix_calc_pkg::IDLE;
			end
			matrix_calc_pkg::ERROR: begin
				if (timer_expired)
					next_state = matrix_calc_pkg::IDLE;
			end
			default: next_state = matrix_calc_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= matrix_calc_pkg::IDLE;
			op_q <= '0;
			scalar_q <= '0;
			load_err_q <= 1'b0;
			alu_start <= 1'b0;
			send_start <= 1'b0;
		end else begin
			state <= next_state;
			alu_start <= (state == matrix_calc_pkg::CHECK) && !bad_cmd;
			send_start <= (state == matrix_calc_pkg::COMPUTE) && alu_done && alu_ok;
			if (state == matrix_calc_pkg::IDLE && confirm && !timer_active) begin
				op_q <= command[2:0];
				scalar_q <= scalar_in;
			end
			if (state == matrix_calc_pkg::IDLE)
				load_err_q <= 1'b0;  // consumed here
			else if (load_error && state != matrix_calc_pkg::ERROR)
				load_err_q <= 1'b1;
		end
	end

	// timer starts on the edge that enters ERROR, error drops with expired
	assign timer_start = (next_state == matrix_calc_pkg::ERROR) && (state != matrix_calc_pkg::ERROR);
	assign error       = (state == matrix_calc_pkg::ERROR) && !timer_expired;
	assign busy        = state inside {matrix_calc_pkg::CHECK, matrix_calc_pkg::COMPUTE,
		matrix_calc_pkg::SEND};
	assign op          = matrix_calc_pkg::op_e'(op_q);
	assign scalar      = scalar_q;

	state_legal: assert property (@(posedge clk) disable iff (!rst_n)
		state inside {matrix_calc_pkg::IDLE, matrix_calc_pkg::CHECK, matrix_calc_pkg::COMPUTE,
			matrix_calc_pkg::SEND, matrix_calc_pkg::ERROR});

endmodule

// File: src/matrix_calc_top.sv
/* byte stream in, result bytes out; the result is complete when busy falls
   tx_start only fires with tx_busy low, the sink raises tx_busy to hold it off */
`timescale 1ns/100ps

module matrix_calc_top (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       rx_valid,
	input  logic [7:0] rx_data,
	input  logic [7:0] command,
	input  logic [7:0] scalar_in,
	input  logic       confirm,
	input  logic       tx_busy,
	output logic       tx_start,
	output logic [7:0] tx_data,
	output logic       busy,
	output logic       error,
	output logic       timer_active
);

	// loader to store
	logic                   wr_en, wr_slot, load_error;
	matrix_calc_pkg::dim_t  wr_m, wr_n;
	matrix_calc_pkg::mat_t  wr_data;
	// store to ALU
	matrix_calc_pkg::dim_t  a_m, a_n, b_m, b_n;
	matrix_calc_pkg::mat_t  a_data, b_data;
	logic                   a_valid, b_valid;
	// FSM, ALU and sender
	logic                   alu_start, alu_done, alu_ok;
	logic                   send_start, send_done;
	logic                   timer_start, timer_expired;
	matrix_calc_pkg::op_e   op;
	matrix_calc_pkg::elem_t scalar;
	matrix_calc_pkg::dim_t  res_m, res_n;
	matrix_calc_pkg::idx_t  rd_idx;
	matrix_calc_pkg::res_t  rd_elem;

	matrix_loader u_loader (.clk, .rst_n, .rx_valid, .rx_data, .wr_en, .wr_slot,
		.wr_m, .wr_n, .wr_data, .load_error);

	matrix_store u_store (.clk, .rst_n, .wr_en, .wr_slot, .wr_m, .wr_n, .wr_data,
		.a_m, .a_n, .a_data, .a_valid, .b_m, .b_n, .b_data, .b_valid);

	matrix_alu u_alu (.clk, .rst_n, .alu_start, .op, .scalar,
		.a_m, .a_n, .a_data, .a_valid, .b_m, .b_n, .b_data, .b_valid,
		.rd_idx, .alu_done, .alu_ok, .res_m, .res_n, .rd_elem);

	result_sender u_sender (.clk, .rst_n, .send_start, .tx_busy, .res_m, .res_n,
		.rd_elem, .rd_idx, .tx_start, .tx_data, .send_done);

	countdown_timer u_timer (.clk, .rst_n, .timer_start, .active(timer_active),
		.expired(timer_expired));

	calc_fsm u_fsm (.clk, .rst_n, .confirm, .command, .scalar_in, .load_error,
		.alu_done, .alu_ok, .send_done, .timer_active, .timer_expired,
		.alu_start, .op, .scalar, .send_start, .timer_start, .busy, .error);

endmodule

// File: dv/tb_clk_gen.sv
/* free-running 8 ns clock, rst_n held low for the first 8 rising edges */
`timescale 1ns/100ps

module tb_clk_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;  // 8 ns period
	end

	initial begin
		rst_n = 1'b0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;  // released on an edge like all other stimulus
	end

endmodule

// File: dv/matrix_calc_tb.sv
/* vectors come from dv/golden_vectors.txt, so the run starts in the project root
   DUT state carries from test to test, the slot order in the file depends on it */
`timescale 1ns/100ps

module matrix_calc_tb;

	logic             clk, rst_n;
	logic             rx_valid, confirm, tx_busy;
	logic [7:0]       rx_data, command, scalar_in;
	logic             tx_start, busy, error, timer_active;
	logic [7:0]       tx_data;
	logic [7:0]       sent_q[$];      // bytes taken by the sink
	logic [8*32-1:0]  tok, test_name;  // words from the vector file
	logic [8*128-1:0] rest_of_line;
	int               fd, code, hold, cycles;
	int               n_tests, n_bad_tests, n_errors, test_start_errors;
	int               vals[64];        // numbers of one record line
	int               cycle_limit = 8 * 500;  // 8 tests, 500 cycles worst case each

	tb_clk_gen u_clk_gen (.clk, .rst_n);

	matrix_calc_top dut0 (.clk, .rst_n, .rx_valid, .rx_data, .command, .scalar_in,
		.confirm, .tx_busy, .tx_start, .tx_data, .busy, .error, .timer_active);

	// ==================================================
	// byte sink and watchdog
	// ==================================================
	initial begin
		void'($urandom(32'h31a6e303));  // one seed for the whole run
		tx_busy = 1'b0;
		hold = 0;
		forever begin
			@(posedge clk);
			if (tx_start === 1'b1) begin
				sent_q.push_back(tx_data);
				hold = $urandom % 4;  // 0..3 busy cycles per byte
			end else if (hold > 0) begin
				hold = hold - 1;
			end else if ($urandom % 16 == 0) begin
				hold = 1;  // stray busy, no byte behind it
			end
			tx_busy <= (hold > 0);
		end
	end

	initial begin
		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run still going after %0d cycles, in test %0s", cycles, test_name);
		$display("Checks failed");
		$finish;
	end

	// ==================================================
	// helpers
	// ==================================================
	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		if (got !== exp) begin
			$display("CHECK FAILED at %0d ns: %s, got %0d expected %0d", $time, what, got, exp);
			n_errors++;
		end
	endtask

	task automatic read_values(input int count);
		int i;
		int v;
		for (i = 0; i < count && i < 64; i++) begin
			if ($fscanf(fd, "%d", v) != 1) begin
				$display("vector file ends inside a record of test %0s", test_name);
				n_errors++;
			end
			vals[i] = v;
		end
	endtask

	task automatic send_bytes(input int count);
		int i;
		for (i = 0; i < count; i++) begin
			@(posedge clk);
			rx_valid <= 1'b1;
			rx_data  <= 8'(vals[i]);
		end
		@(posedge clk);
		rx_valid <= 1'b0;
	endtask

	// error must hold for 48 cycles, 16-cycle ticks times three
	task automatic check_error_hold();
		int held;
		int i;
		held = 0;
		do @(posedge clk); while (error !== 1'b1);
		check_value(timer_active, 1, "timer_active with error");
		check_value(sent_q.size(), 0, "bytes sent for a refused request");
		while (error === 1'b1) begin
			held++;
			confirm <= (held == 10);  // a confirm here must be dropped
			check_value(busy, 0, "busy during error hold");
			@(posedge clk);
		end
		confirm <= 1'b0;
		check_value(held, 48, "error hold cycles");
		for (i = 0; i < 4; i++) begin
			@(posedge clk);
			check_value(busy, 0, "busy after error hold");
		end
		check_value(sent_q.size(), 0, "bytes after error hold");
	endtask

	task automatic run_request(input int cmd, input int sc, input int err, input int nexp);
		int i;
		sent_q.delete();  // core idle, nothing in flight
		@(posedge clk);
		command   <= 8'(cmd);
		scalar_in <= 8'(sc);
		confirm   <= 1'b1;
		@(posedge clk);
		confirm <= 1'b0;
		if (err != 0) begin
			check_error_hold();
		end else begin
			do @(posedge clk); while (busy !== 1'b1);
			do @(posedge clk); while (busy === 1'b1);  // stream complete
			check_value(error, 0, "error on a good request");
			check_value(sent_q.size(), nexp, "result byte count");
			for (i = 0; i < nexp && i < sent_q.size(); i++)
				check_value(sent_q[i], vals[i], $sformatf("result byte %0d", i));
		end
	endtask

	task automatic apply_keyword();
		int n, cmd, sc, err;
		if (tok == "#") begin
			code = $fgets(rest_of_line, fd);  // comment line
		end else if (tok == "test") begin
			code = $fscanf(fd, "%s", test_name);
			test_start_errors = n_errors;
			n_tests++;
		end else if (tok == "load") begin
			code = $fscanf(fd, "%d", n);
			read_values(n);
			send_bytes(n);
		end else if (tok == "run") begin
			code = $fscanf(fd, "%d %d %d %d", cmd, sc, err, n);
			read_values(n);
			run_request(cmd, sc, err, n);
		end else if (tok == "loaderr") begin
			check_error_hold();  // no confirm, the bad byte alone trips it
		end else if (tok == "end") begin
			if (n_errors == test_start_errors) begin
				$display("test %0s: ok", test_name);
			end else begin
				$display("test %0s: %0d mismatches", test_name, n_errors - test_start_errors);
				n_bad_tests++;
			end
		end else begin
			$display("unknown word %0s in the vector file", tok);
			n_errors++;
		end
	endtask

	// ==================================================
	// main sequence
	// ==================================================
	initial begin
		rx_valid  = 1'b0;
		rx_data   = 8'd0;
		command   = 8'd0;
		scalar_in = 8'd0;
		confirm   = 1'b0;
		n_tests = 0;
		n_bad_tests = 0;
		n_errors = 0;
		test_name = "none";
		fd = $fopen("dv/golden_vectors.txt", "r");
		if (fd == 0) begin
			$display("cannot open dv/golden_vectors.txt from the current directory");
			$display("Checks failed");
			$finish;
		end else begin
			@(posedge rst_n);
			repeat (2) @(posedge clk);
			while (!$feof(fd)) begin
				code = $fscanf(fd, "%s", tok);
				if (code == 1)
					apply_keyword();
			end
			$fclose(fd);
			repeat (4) @(posedge clk);
			$display("%0d tests run, %0d failed, %0d mismatches", n_tests, n_bad_tests, n_errors);
			if (n_errors == 0 && n_tests > 0)
				$display("All checks passed");
			else
				$display("Checks failed");
			$finish;
		end
	end

endmodule

// File: dv/golden_vectors.txt
# words: test NAME | load COUNT bytes | run CMD SCALAR ERR COUNT bytes | loaderr | end
# decimal numbers, ERR 1 expects a 48-cycle error hold and no result bytes
test transpose
load 8 2 3 1 2 3 4 5 6
run 0 0 0 14 3 2 0 1 0 4 0 2 0 5 0 3 0 6
end
test scalar_9
run 1 9 0 14 2 3 0 9 0 18 0 27 0 36 0 45 0 54
end
test scalar_12
run 1 12 1 0
end
test add
load 8 2 3 9 8 7 9 9 9
run 2 0 0 14 2 3 0 10 0 10 0 10 0 13 0 14 0 15
end
test multiply
load 8 2 3 1 2 3 4 5 6
load 8 3 2 7 8 9 1 2 3
run 3 0 0 10 2 2 0 31 0 19 0 85 0 55
end
# all nines, every element 405 = 1 * 256 + 149
test multiply_nines
load 27 5 5 9 9 9 9 9 9 9 9 9 9 9 9 9
9 9 9 9 9 9 9 9 9 9 9 9
load 27 5 5 9 9 9 9 9 9 9 9 9 9 9 9 9
9 9 9 9 9 9 9 9 9 9 9 9
run 3 0 0 52 5 5
1 149 1 149 1 149 1 149 1 149 1 149 1 149 1 149 1 149
1 149 1 149 1 149 1 149 1 149 1 149 1 149 1 149
1 149 1 149 1 149 1 149 1 149 1 149 1 149 1 149
end
test add_mismatch
load 8 2 3 1 0 2 0 3 0
load 8 3 2 1 1 1 1 1 1
run 2 0 1 0
end
# the good load after the bad one must land in slot A
test bad_element
load 3 2 2 10
loaderr
load 8 3 2 2 4 6 8 1 3
run 2 0 0 14 3 2 0 3 0 5 0 7 0 9 0 2 0 4
end

// File: files.f
src/matrix_calc_pkg.sv
src/matrix_loader.sv
src/matrix_store.sv
src/matrix_alu.sv
src/result_sender.sv
src/countdown_timer.sv
src/calc_fsm.sv
src/matrix_calc_top.sv
dv/tb_clk_gen.sv
dv/matrix_calc_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the matrix calculator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f files.f \
	--top-module matrix_calc_tb -Mdir obj_dir

./obj_dir/Vmatrix_calc_tb > sim.log 2>&1
cat sim.log

if grep -q "Checks failed" sim.log; then
	echo "simulation FAILED, see sim.log"
	exit 1
fi
echo "simulation passed"
